// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --top-module tb_video_sync -f tb.f -o tb_video_sync
./obj_dir/tb_video_sync | tee sim.log

if grep -q "Test failures found" sim.log
then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"

// File: tb.f
video_pkg.sv
video_clk_en.sv
video_sync_h.sv
video_sync_v.sv
video_mode_regs.sv
video_sync_top.sv
tb_video_sync.sv

// File: tb_video_sync.sv
`timescale 1ns/100ps

module tb_video_sync;

	localparam int CLK_PERIOD  = 20;
	localparam int LINE_CLKS   = int'(video_pkg::HPERIOD) * video_pkg::CEN_DIV;
	localparam int FRAME_CLKS  = LINE_CLKS * int'(video_pkg::VPERIOD);
	localparam int RUN_FRAMES  = 6;    // Test sequence spends a little over five frames.
	localparam int WATCHDOG_NS = (RUN_FRAMES * FRAME_CLKS + 100000) * CLK_PERIOD;
	localparam int HS_TIMEOUT  = 16;

	typedef struct packed {
		video_pkg::video_level_t  level;
		video_pkg::video_strobe_t strobe;
	} raster_t;

	logic                     clk;
	logic                     reset;
	video_pkg::axil_req_t     axil;
	video_pkg::axil_rsp_t     axil_rsp;
	video_pkg::video_level_t  levels;
	video_pkg::video_strobe_t strobes;

	// Model of the raster, advanced at each falling edge to the state after the next rising edge.
	int                     m_phase;
	video_pkg::hcount_t     m_hcount;
	video_pkg::vcount_t     m_vcount;
	raster_t                m_out;
	logic [3:0]             m_fetch_sr;
	video_pkg::video_mode_t m_mode;
	int                     m_init_left;
	video_pkg::frame_cnt_t  m_frames;
	video_pkg::frame_cnt_t  exp_status;

	logic                    compare_on;
	string                   test_name;
	int                      test_errors;
	int                      tests_run;
	int                      tests_failed;
	int                      i;
	int                      int_count;
	int                      vsync_rise;
	logic [1:0]              resp;
	logic [31:0]             rng;
	video_pkg::axil_data_t   data;
	video_pkg::axil_data_t   rdata;
	video_pkg::axil_addr_t   addr;
	video_pkg::video_level_t prev_levels;
	logic                    prev_hsync;

	video_sync_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.axil     (axil),
		.axil_rsp (axil_rsp),
		.levels   (levels),
		.strobes  (strobes)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Simulation timed out after %0d ns, the test sequence did not finish", WATCHDOG_NS);
		$display("Test failures found");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ----------------------------------------
	// Reference raster
	// ----------------------------------------
	function automatic raster_t raster_next(input raster_t cur, input video_pkg::hcount_t h,
		input video_pkg::vcount_t v, input video_pkg::video_mode_t mode, input int phase,
		input logic [3:0] fetch_sr);
		raster_t            nxt;
		video_pkg::hcount_t pix_beg;
		video_pkg::hcount_t pix_end;
		logic               pre;
		nxt     = cur;
		pix_beg = mode.atm_n_pent ? video_pkg::HPIX_BEG_ATM : video_pkg::HPIX_BEG_PENT;
		pix_end = mode.atm_n_pent ? video_pkg::HPIX_END_ATM : video_pkg::HPIX_END_PENT;
		pre     = (phase == video_pkg::CEN_DIV - 2);
		if (phase == video_pkg::CEN_DIV - 1)
		begin
			if (h == video_pkg::HBLNK_BEG)
				nxt.level.hblank = 1'b1;
			else if (h == video_pkg::HBLNK_END)
				nxt.level.hblank = 1'b0;
			if (h == video_pkg::HSYNC_BEG)
				nxt.level.hsync = 1'b1;
			else if (h == video_pkg::HSYNC_END)
				nxt.level.hsync = 1'b0;
			if (h == pix_beg)
				nxt.level.hpix = 1'b1;
			else if (h == pix_end)
				nxt.level.hpix = 1'b0;
		end
		if (cur.strobe.hsync_start)
		begin
			if (v == video_pkg::VBLNK_BEG)
				nxt.level.vblank = 1'b1;
			else if (v == video_pkg::VBLNK_END)
				nxt.level.vblank = 1'b0;
			if (v == video_pkg::VSYNC_BEG)
				nxt.level.vsync = 1'b1;
			else if (v == video_pkg::VSYNC_END)
				nxt.level.vsync = 1'b0;
			if (v == video_pkg::VPIX_BEG)
				nxt.level.vpix = 1'b1;
			else if (v == video_pkg::VPIX_END)
				nxt.level.vpix = 1'b0;
		end
		nxt.strobe.line_start   = pre && (h == video_pkg::HBLNK_END);
		nxt.strobe.hsync_start  = pre && (h == video_pkg::HSYNC_BEG);
		nxt.strobe.hint_start   = pre && (h == video_pkg::HINT_BEG);
		nxt.strobe.scanin_start = pre && (h == video_pkg::SCANIN_BEG);
		nxt.strobe.fetch_start  = pre && (mode.a_text ? (h == pix_beg - 9'd22) : fetch_sr[3]);
		nxt.strobe.fetch_end    = pre && (h == pix_end - 9'd18);
		nxt.strobe.frame_int    = 1'b0;    // Derived from the line number at compare time.
		return nxt;
	endfunction

	always @(negedge clk)
	begin : model_compare
		raster_t            exp_out;
		raster_t            next_out;
		video_pkg::hcount_t pix_beg;
		logic               cend_now;
		logic               init_now;
		exp_out                  = m_out;
		exp_out.strobe.frame_int = m_out.strobe.hint_start && (m_vcount == video_pkg::VINT_BEG);
		if (compare_on && (levels !== exp_out.level || strobes !== exp_out.strobe))
		begin
			if (test_errors == 0)
				$display("Error: test %s, expected levels %b strobes %b, actual levels %b strobes %b",
					test_name, exp_out.level, exp_out.strobe, levels, strobes);
			test_errors++;
		end
		if (reset)
		begin
			m_phase     = 0;
			m_hcount    = '0;
			m_vcount    = '0;
			m_out       = '0;
			m_fetch_sr  = '0;
			m_mode      = '0;
			m_init_left = 0;
			m_frames    = '0;
		end
		else
		begin
			cend_now = (m_phase == video_pkg::CEN_DIV - 1);
			init_now = (m_init_left != 0);
			pix_beg  = m_mode.atm_n_pent ? video_pkg::HPIX_BEG_ATM : video_pkg::HPIX_BEG_PENT;
			next_out = raster_next(m_out, m_hcount, m_vcount, m_mode, m_phase, m_fetch_sr);
			if (axil_rsp.arready && axil.araddr == video_pkg::REG_STATUS)
				exp_status = m_frames;    // Read data is taken at acceptance.
			if (init_now)
				m_frames = '0;
			else if (exp_out.strobe.frame_int)
				m_frames = m_frames + 16'd1;
			if (cend_now && init_now)
				m_vcount = '0;
			else if (m_out.strobe.hsync_start)
				m_vcount = (m_vcount == video_pkg::VPERIOD - 9'd1) ? 9'd0 : m_vcount + 9'd1;
			if (cend_now)
			begin
				m_fetch_sr = {m_fetch_sr[2:0], m_hcount == pix_beg - 9'd22};
				if (init_now || m_hcount == video_pkg::HPERIOD - 9'd1)
					m_hcount = '0;
				else
					m_hcount = m_hcount + 9'd1;
			end
			if (axil_rsp.awready && axil.wstrb[0] && axil.awaddr == video_pkg::REG_CTRL
				&& axil.wdata[0])
				m_init_left = 4;
			else if (m_init_left > 0)
				m_init_left--;
			if (axil_rsp.awready && axil.wstrb[0] && axil.awaddr == video_pkg::REG_MODE)
				m_mode = video_pkg::video_mode_t'(axil.wdata[1:0]);
			m_phase = (m_phase + 1) % video_pkg::CEN_DIV;
			m_out   = next_out;
		end
	end

	// ----------------------------------------
	// AXI4-Lite master
	// ----------------------------------------
	task automatic axi_write(input video_pkg::axil_addr_t waddr, input video_pkg::axil_data_t wdata,
		input int delay, output logic [1:0] bresp);
		int tries;
		@(posedge clk);
		#2;
		axil.awaddr  = waddr;
		axil.awvalid = 1'b1;
		axil.wdata   = wdata;
		axil.wstrb   = 4'hf;
		axil.wvalid  = 1'b1;
		tries        = 0;
		@(negedge clk);
		while (!(axil_rsp.awready && axil_rsp.wready) && tries < HS_TIMEOUT)
		begin
			tries++;
			@(negedge clk);
		end
		if (!(axil_rsp.awready && axil_rsp.wready))
		begin
			$display("Test %s: the write to address %h was never accepted", test_name, waddr);
			test_errors++;
		end
		@(posedge clk);
		#2;
		axil.awvalid = 1'b0;
		axil.wvalid  = 1'b0;
		tries        = 0;
		@(negedge clk);
		while (!axil_rsp.bvalid && tries < HS_TIMEOUT)
		begin
			tries++;
			@(negedge clk);
		end
		if (!axil_rsp.bvalid)
		begin
			$display("Test %s: no write response came for address %h", test_name, waddr);
			test_errors++;
		end
		bresp = axil_rsp.bresp;
		repeat (delay)
		begin
			@(negedge clk);
			if (!axil_rsp.bvalid)
			begin
				$display("Test %s: bvalid was low while bready was held off", test_name);
				test_errors++;
			end
		end
		@(posedge clk);
		#2;
		axil.bready = 1'b1;
		@(posedge clk);
		#2;
		axil.bready = 1'b0;
	endtask

	task automatic axi_read(input video_pkg::axil_addr_t raddr, input int delay,
		output video_pkg::axil_data_t rd, output logic [1:0] rresp);
		int tries;
		@(posedge clk);
		#2;
		axil.araddr  = raddr;
		axil.arvalid = 1'b1;
		tries        = 0;
		@(negedge clk);
		while (!axil_rsp.arready && tries < HS_TIMEOUT)
		begin
			tries++;
			@(negedge clk);
		end
		if (!axil_rsp.arready)
		begin
			$display("Test %s: the read of address %h was never accepted", test_name, raddr);
			test_errors++;
		end
		@(posedge clk);
		#2;
		axil.arvalid = 1'b0;
		tries        = 0;
		@(negedge clk);
		while (!axil_rsp.rvalid && tries < HS_TIMEOUT)
		begin
			tries++;
			@(negedge clk);
		end
		if (!axil_rsp.rvalid)
		begin
			$display("Test %s: no read data came for address %h", test_name, raddr);
			test_errors++;
		end
		rd    = axil_rsp.rdata;
		rresp = axil_rsp.rresp;
		repeat (delay)
		begin
			@(negedge clk);
			if (!axil_rsp.rvalid)
			begin
				$display("Test %s: rvalid was low while rready was held off", test_name);
				test_errors++;
			end
		end
		@(posedge clk);
		#2;
		axil.rready = 1'b1;
		@(posedge clk);
		#2;
		axil.rready = 1'b0;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Error: test %s, %s expected %h, actual %h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic finish_test;
		tests_run++;
		if (test_errors != 0)
		begin
			tests_failed++;
			$display("Test %s failed with %0d errors", test_name, test_errors);
		end
		else
		begin
			$display("Test %s passed", test_name);
		end
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial
	begin
		axil         = '0;
		reset        = 1'b1;
		compare_on   = 1'b0;
		test_name    = "reset";
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		rng          = 32'hd0bd_80e8;
		repeat (3) @(posedge clk);
		#2;
		reset      = 1'b0;
		compare_on = 1'b1;

		start_test("registers");
		for (i = 0; i < 4; i++)
		begin
			rng  = xorshift32(rng);
			data = rng;
			axi_write(video_pkg::REG_MODE, data, i, resp);
			check_value("mode write bresp", {30'd0, video_pkg::RESP_OKAY}, {30'd0, resp});
			axi_read(video_pkg::REG_MODE, 3 - i, rdata, resp);
			check_value("mode read rresp", {30'd0, video_pkg::RESP_OKAY}, {30'd0, resp});
			check_value("mode read data", data & 32'h3, rdata);
		end
		rng  = xorshift32(rng);
		addr = {rng[7:4], 4'hc};    // Never one of the three mapped words.
		axi_read(addr, 5, rdata, resp);
		check_value("unmapped rresp", {30'd0, video_pkg::RESP_SLVERR}, {30'd0, resp});
		check_value("unmapped rdata", 32'd0, rdata);
		axi_write(video_pkg::REG_STATUS, rng, 4, resp);
		check_value("status write bresp", {30'd0, video_pkg::RESP_SLVERR}, {30'd0, resp});
		finish_test();

		start_test("pentagon_graphics");
		axi_write(video_pkg::REG_MODE, 32'h0, 0, resp);
		repeat (2 * FRAME_CLKS) @(posedge clk);
		finish_test();

		start_test("vertical_timing");
		int_count  = 0;
		vsync_rise = 0;
		@(negedge clk);
		prev_levels = levels;
		prev_hsync  = strobes.hsync_start;
		repeat (FRAME_CLKS)
		begin
			@(negedge clk);
			if (strobes.frame_int)
				int_count++;
			if (strobes.frame_int && !strobes.hint_start)
			begin
				$display("Test %s: frame_int came without hint_start", test_name);
				test_errors++;
			end
			if (levels.vsync && !prev_levels.vsync)
				vsync_rise++;
			if ({levels.vblank, levels.vsync, levels.vpix} !==
				{prev_levels.vblank, prev_levels.vsync, prev_levels.vpix} && !prev_hsync)
			begin
				$display("Test %s: a vertical level changed away from hsync_start", test_name);
				test_errors++;
			end
			prev_levels = levels;
			prev_hsync  = strobes.hsync_start;
		end
		check_value("frame_int count", 32'd1, int_count);
		check_value("vsync rise count", 32'd1, vsync_rise);
		finish_test();

		start_test("atm_text");
		axi_write(video_pkg::REG_MODE, 32'h3, 0, resp);
		repeat (FRAME_CLKS) @(posedge clk);
		finish_test();

		start_test("init_resync");
		rng = xorshift32(rng);
		repeat (1000 + int'(rng % 32'd150000)) @(posedge clk);
		axi_write(video_pkg::REG_CTRL, 32'h1, 0, resp);
		check_value("ctrl write bresp", {30'd0, video_pkg::RESP_OKAY}, {30'd0, resp});
		repeat (8 * LINE_CLKS) @(posedge clk);
		#2;
		check_value("hcount", {23'd0, m_hcount}, {23'd0, i_dut.i_sync_h.hcount});
		check_value("vcount", {23'd0, m_vcount}, {23'd0, i_dut.i_sync_v.vcount});
		// Eight hsync_start pulses have passed since the init cend.
		check_value("lines since init", 32'd8, {23'd0, i_dut.i_sync_v.vcount});
		finish_test();

		start_test("frame_counter");
		axi_read(video_pkg::REG_STATUS, 0, rdata, resp);
		check_value("status rresp", {30'd0, video_pkg::RESP_OKAY}, {30'd0, resp});
		check_value("status after init", {16'd0, exp_status}, rdata);
		repeat (FRAME_CLKS) @(posedge clk);
		axi_read(video_pkg::REG_STATUS, 2, rdata, resp);
		check_value("status after a frame", {16'd0, exp_status}, rdata);
		check_value("frames since init", 32'd2, rdata);
		finish_test();

		$display("%0d tests run, %0d failed", tests_run, tests_failed);
		if (tests_failed == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: video_clk_en.sv
`timescale 1ns/100ps

module video_clk_en (
	input  logic clk,
	input  logic reset,
	output logic pre_cend,
	output logic cend
);

	localparam logic [1:0] LAST_PHASE = 2'(video_pkg::CEN_DIV - 1);
	localparam logic [1:0] PRE_PHASE  = 2'(video_pkg::CEN_DIV - 2);

	logic [1:0] phase;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			phase <= 2'd0;
		end
		else if (phase == LAST_PHASE)
		begin
			phase <= 2'd0;
		end
		else
		begin
			phase <= phase + 2'd1;
		end
	end

	// pre_cend leads cend by one clock so strobes can be registered in time.
	assign pre_cend = (phase == PRE_PHASE);
	assign cend     = (phase == LAST_PHASE);

endmodule

// File: video_mode_regs.sv
`timescale 1ns/100ps

module video_mode_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  video_pkg::axil_req_t   axil,
	input  logic                   frame_int,
	output video_pkg::axil_rsp_t   axil_rsp,
	output video_pkg::video_mode_t mode,
	output logic                   init
);

	video_pkg::regs_state_t state;
	video_pkg::frame_cnt_t  frame_cnt;
	video_pkg::axil_data_t  rdata;
	logic [1:0]             bresp;
	logic [1:0]             rresp;
	logic [2:0]             init_cnt;
	logic                   wr_accept;
	logic                   rd_accept;

	// Writes take priority when both channels arrive together.
	assign wr_accept = (state == video_pkg::IDLE) && axil.awvalid && axil.wvalid;
	assign rd_accept = (state == video_pkg::IDLE) && axil.arvalid && !(axil.awvalid && axil.wvalid);

	// ----------------------------------------
	// Handshake FSM
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= video_pkg::IDLE;
		else
		begin
			case (state)
				video_pkg::IDLE:
				begin
					if (wr_accept)
						state <= video_pkg::WRITE_RESP;
					else if (rd_accept)
						state <= video_pkg::READ_RESP;
				end
				video_pkg::WRITE_RESP:
					if (axil.bready)
						state <= video_pkg::IDLE;
				video_pkg::READ_RESP:
					if (axil.rready)
						state <= video_pkg::IDLE;
				default:
					state <= video_pkg::IDLE;
			endcase
		end
	end

	// ----------------------------------------
	// Register writes and init stretcher
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mode     <= '0;
			init_cnt <= 3'd0;
		end
		else
		begin
			if (init_cnt != 3'd0)
				init_cnt <= init_cnt - 3'd1;
			if (wr_accept && axil.wstrb[0])
			begin
				if (axil.awaddr == video_pkg::REG_MODE)
					mode <= video_pkg::video_mode_t'(axil.wdata[1:0]);
				if (axil.awaddr == video_pkg::REG_CTRL && axil.wdata[0])
					init_cnt <= 3'd4;    // Covers exactly one cend.
			end
		end
	end

	assign init = (init_cnt != 3'd0);

	always_ff @(posedge clk)
	begin
		if (reset || init)
			frame_cnt <= '0;
		else if (frame_int)
			frame_cnt <= frame_cnt + 16'd1;
	end

	// Response payloads are captured at acceptance.
	always_ff @(posedge clk)
	begin
		if (wr_accept)
		begin
			if (axil.awaddr == video_pkg::REG_MODE || axil.awaddr == video_pkg::REG_CTRL)
				bresp <= video_pkg::RESP_OKAY;
			else
				bresp <= video_pkg::RESP_SLVERR;
		end
		if (rd_accept)
		begin
			rresp <= video_pkg::RESP_OKAY;
			case (axil.araddr)
				video_pkg::REG_MODE:   rdata <= {30'd0, mode};
				video_pkg::REG_CTRL:   rdata <= '0;
				video_pkg::REG_STATUS: rdata <= {16'd0, frame_cnt};
				default:
				begin
					rdata <= '0;
					rresp <= video_pkg::RESP_SLVERR;
				end
			endcase
		end
	end

	always_comb
	begin
		axil_rsp.awready = wr_accept;
		axil_rsp.wready  = wr_accept;
		axil_rsp.bresp   = bresp;
		axil_rsp.bvalid  = (state == video_pkg::WRITE_RESP);
		axil_rsp.arready = rd_accept;
		axil_rsp.rdata   = rdata;
		axil_rsp.rresp   = rresp;
		axil_rsp.rvalid  = (state == video_pkg::READ_RESP);
	end

endmodule

// File: video_pkg.sv
package video_pkg;

	// ----------------------------------------
	// Count and bus types
	// ----------------------------------------
	typedef logic [8:0]  hcount_t;    // Pixel-clock position within a line.
	typedef logic [8:0]  vcount_t;    // Line number within a frame.
	typedef logic [15:0] frame_cnt_t;
	typedef logic [7:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;

	// ----------------------------------------
	// Raster geometry
	// ----------------------------------------
	localparam hcount_t HBLNK_BEG     = 9'd0;
	localparam hcount_t HBLNK_END     = 9'd88;
	localparam hcount_t HSYNC_BEG     = 9'd10;
	localparam hcount_t HSYNC_END     = 9'd43;
	localparam hcount_t HPIX_BEG_PENT = 9'd140;
	localparam hcount_t HPIX_END_PENT = 9'd396;
	localparam hcount_t HPIX_BEG_ATM  = 9'd108;
	localparam hcount_t HPIX_END_ATM  = 9'd428;
	localparam hcount_t FETCH_FOREGO  = 9'd18;    // Fetch runs ahead of the pixel window.
	localparam hcount_t SCANIN_BEG    = 9'd88;
	localparam hcount_t HINT_BEG      = 9'd2;
	localparam hcount_t HPERIOD       = 9'd448;

	localparam vcount_t VBLNK_BEG = 9'd0;
	localparam vcount_t VBLNK_END = 9'd32;
	localparam vcount_t VSYNC_BEG = 9'd8;
	localparam vcount_t VSYNC_END = 9'd12;
	localparam vcount_t VPIX_BEG  = 9'd80;
	localparam vcount_t VPIX_END  = 9'd272;
	localparam vcount_t VINT_BEG  = 9'd0;
	localparam vcount_t VPERIOD   = 9'd320;

	localparam int CEN_DIV = 4;    // System clocks per pixel count.

	// ----------------------------------------
	// Register map
	// ----------------------------------------
	localparam axil_addr_t REG_MODE   = 8'h00;
	localparam axil_addr_t REG_CTRL   = 8'h04;
	localparam axil_addr_t REG_STATUS = 8'h08;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic atm_n_pent;
		logic a_text;
	} video_mode_t;

	typedef struct packed {
		logic hblank;
		logic hsync;
		logic hpix;
		logic vblank;
		logic vsync;
		logic vpix;
	} video_level_t;

	typedef struct packed {
		logic line_start;
		logic hsync_start;
		logic hint_start;
		logic scanin_start;
		logic fetch_start;
		logic fetch_end;
		logic frame_int;
	} video_strobe_t;

	typedef struct packed {
		axil_addr_t awaddr;
		logic       awvalid;
		axil_data_t wdata;
		logic [3:0] wstrb;
		logic       wvalid;
		logic       bready;
		axil_addr_t araddr;
		logic       arvalid;
		logic       rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic [1:0] bresp;
		logic       bvalid;
		logic       arready;
		axil_data_t rdata;
		logic [1:0] rresp;
		logic       rvalid;
	} axil_rsp_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITE_RESP,
		READ_RESP
	} regs_state_t;

endpackage

// File: video_sync_h.sv
`timescale 1ns/100ps

module video_sync_h (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  init,
	input  logic                  cend,
	input  logic                  pre_cend,
	input  video_pkg::video_mode_t mode,
	output logic                  hblank,
	output logic                  hsync,
	output logic                  hpix,
	output logic                  line_start,
	output logic                  hsync_start,
	output logic                  hint_start,
	output logic                  scanin_start,
	output logic                  fetch_start,
	output logic                  fetch_end
);

	video_pkg::hcount_t hcount;
	video_pkg::hcount_t hpix_beg;
	video_pkg::hcount_t hpix_end;
	video_pkg::hcount_t fetch_beg;
	video_pkg::hcount_t fetch_fin;
	logic               fetch_start_time;
	logic               fetch_end_time;
	logic               fetch_start_cond;
	logic [3:0]         fetch_wait;

	// ----------------------------------------
	// Line counter
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hcount <= '0;
		end
		else if (cend)
		begin
			if (init || hcount == video_pkg::HPERIOD - 9'd1)
				hcount <= '0;
			else
				hcount <= hcount + 9'd1;
		end
	end

	// Pixel window depends on the raster geometry.
	assign hpix_beg = mode.atm_n_pent ? video_pkg::HPIX_BEG_ATM : video_pkg::HPIX_BEG_PENT;
	assign hpix_end = mode.atm_n_pent ? video_pkg::HPIX_END_ATM : video_pkg::HPIX_END_PENT;

	// ----------------------------------------
	// Levels
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hblank <= 1'b0;
			hsync  <= 1'b0;
			hpix   <= 1'b0;
		end
		else if (cend)
		begin
			if (hcount == video_pkg::HBLNK_BEG)
				hblank <= 1'b1;
			else if (hcount == video_pkg::HBLNK_END)
				hblank <= 1'b0;
			if (hcount == video_pkg::HSYNC_BEG)
				hsync <= 1'b1;
			else if (hcount == video_pkg::HSYNC_END)
				hsync <= 1'b0;
			if (hcount == hpix_beg)
				hpix <= 1'b1;
			else if (hcount == hpix_end)
				hpix <= 1'b0;
		end
	end

	// ----------------------------------------
	// Fetch timing
	// ----------------------------------------
	assign fetch_beg        = hpix_beg - video_pkg::FETCH_FOREGO - 9'd4;
	assign fetch_fin        = hpix_end - video_pkg::FETCH_FOREGO;
	assign fetch_start_time = (hcount == fetch_beg);
	assign fetch_end_time   = (hcount == fetch_fin);

	always_ff @(posedge clk)
	begin
		if (reset)
			fetch_wait <= 4'd0;
		else if (cend)
			fetch_wait <= {fetch_wait[2:0], fetch_start_time};    // Four counts of delay.
	end

	// Text mode fetches four counts earlier than graphics.
	assign fetch_start_cond = mode.a_text ? fetch_start_time : fetch_wait[3];

	// ----------------------------------------
	// Strobes
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			line_start   <= 1'b0;
			hsync_start  <= 1'b0;
			hint_start   <= 1'b0;
			scanin_start <= 1'b0;
			fetch_start  <= 1'b0;
			fetch_end    <= 1'b0;
		end
		else
		begin
			line_start   <= pre_cend && (hcount == video_pkg::HBLNK_END);
			hsync_start  <= pre_cend && (hcount == video_pkg::HSYNC_BEG);
			hint_start   <= pre_cend && (hcount == video_pkg::HINT_BEG);
			scanin_start <= pre_cend && (hcount == video_pkg::SCANIN_BEG);
			fetch_start  <= pre_cend && fetch_start_cond;
			fetch_end    <= pre_cend && fetch_end_time;
		end
	end

endmodule

// File: video_sync_top.sv
`timescale 1ns/100ps

module video_sync_top (
	input  logic                     clk,
	input  logic                     reset,
	input  video_pkg::axil_req_t     axil,
	output video_pkg::axil_rsp_t     axil_rsp,
	output video_pkg::video_level_t  levels,
	output video_pkg::video_strobe_t strobes
);

	logic                   pre_cend;
	logic                   cend;
	logic                   init;
	logic                   hblank;
	logic                   hsync;
	logic                   hpix;
	logic                   vblank;
	logic                   vsync;
	logic                   vpix;
	logic                   line_start;
	logic                   hsync_start;
	logic                   hint_start;
	logic                   scanin_start;
	logic                   fetch_start;
	logic                   fetch_end;
	logic                   frame_int;
	video_pkg::video_mode_t mode;

	video_clk_en i_clk_en (
		.clk      (clk),
		.reset    (reset),
		.pre_cend (pre_cend),
		.cend     (cend)
	);

	video_sync_h i_sync_h (
		.clk          (clk),
		.reset        (reset),
		.init         (init),
		.cend         (cend),
		.pre_cend     (pre_cend),
		.mode         (mode),
		.hblank       (hblank),
		.hsync        (hsync),
		.hpix         (hpix),
		.line_start   (line_start),
		.hsync_start  (hsync_start),
		.hint_start   (hint_start),
		.scanin_start (scanin_start),
		.fetch_start  (fetch_start),
		.fetch_end    (fetch_end)
	);

	video_sync_v i_sync_v (
		.clk         (clk),
		.reset       (reset),
		.init        (init),
		.cend        (cend),
		.hsync_start (hsync_start),
		.hint_start  (hint_start),
		.vblank      (vblank),
		.vsync       (vsync),
		.vpix        (vpix),
		.frame_int   (frame_int)
	);

	video_mode_regs i_mode_regs (
		.clk       (clk),
		.reset     (reset),
		.axil      (axil),
		.frame_int (frame_int),
		.axil_rsp  (axil_rsp),
		.mode      (mode),
		.init      (init)
	);

	assign levels  = '{hblank, hsync, hpix, vblank, vsync, vpix};
	assign strobes = '{line_start, hsync_start, hint_start, scanin_start,
		fetch_start, fetch_end, frame_int};

endmodule

// File: video_sync_v.sv
`timescale 1ns/100ps

module video_sync_v (
	input  logic clk,
	input  logic reset,
	input  logic init,
	input  logic cend,
	input  logic hsync_start,
	input  logic hint_start,
	output logic vblank,
	output logic vsync,
	output logic vpix,
	output logic frame_int
);

	video_pkg::vcount_t vcount;

	// ----------------------------------------
	// Frame counter
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vcount <= '0;
		end
		else if (cend && init)
		begin
			vcount <= '0;    // Resync lands on the same cend as the horizontal one.
		end
		else if (hsync_start)
		begin
			if (vcount == video_pkg::VPERIOD - 9'd1)
				vcount <= '0;
			else
				vcount <= vcount + 9'd1;
		end
	end

	// ----------------------------------------
	// Levels
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vblank <= 1'b0;
			vsync  <= 1'b0;
			vpix   <= 1'b0;
		end
		else if (hsync_start)
		begin
			if (vcount == video_pkg::VBLNK_BEG)
				vblank <= 1'b1;
			else if (vcount == video_pkg::VBLNK_END)
				vblank <= 1'b0;

			if (vcount == video_pkg::VSYNC_BEG)
				vsync <= 1'b1;
			else if (vcount == video_pkg::VSYNC_END)
				vsync <= 1'b0;

			if (vcount == video_pkg::VPIX_BEG)
				vpix <= 1'b1;
			else if (vcount == video_pkg::VPIX_END)
				vpix <= 1'b0;
		end
	end

	// One interrupt per frame, aligned with the line interrupt point.
	assign frame_int = hint_start && (vcount == video_pkg::VINT_BEG);

endmodule
